// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_sdu_top
FILELIST  ?= tb.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sdu_chn_arbiter.sv
`timescale 1ns/10ps
// round-robin channel arbiter
// fetches one whole packet, then waits until both readers have taken it
module sdu_chn_arbiter
    import sdu_pkg::*;
#(
    parameter int CHN_NUM = sdu_pkg::CHN_NUM
) (
    input  logic         clk_sys,
    input  logic         rst_sys,
    input  sdu_chn_vec_t chn_sdu_empty,
    input  sdu_chn_vec_t chn_sdu_dval,
    input  logic         eop_in,        // eop of the word accepted this cycle
    input  logic [1:0]   rd_idle,       // one bit per reader
    output sdu_chn_vec_t sdu_chn_rden
);

    sdu_chn_t ptr;          // selected channel
    sdu_chn_t nxt_ptr;
    sdu_chn_t scan_idx;
    logic     nxt_found;
    logic     in_pkt;       // sop taken, eop not yet
    logic     hold;         // blocks the fetch right after an eop
    logic     sel_empty;
    logic     fetch_ok;
    logic     move_idle;

    assign sel_empty = chn_sdu_empty[ptr];
    assign fetch_ok  = (&rd_idle) && !hold && !sel_empty;
    assign move_idle = !in_pkt && sel_empty;  // nothing to fetch here, look elsewhere

    //------------------------------------------------------------
    // read enables
    //------------------------------------------------------------
    always_comb begin
        sdu_chn_rden = '0;
        for (int i = 0; i < CHN_NUM; i++) begin
            sdu_chn_rden[i] = fetch_ok && (ptr == sdu_chn_t'(i));
        end
    end

    //------------------------------------------------------------
    // next non-empty channel after the current one
    //------------------------------------------------------------
    always_comb begin
        nxt_found = 1'b0;
        nxt_ptr   = ptr;  // all others empty, stay put
        scan_idx  = ptr;
        for (int k = 1; k < CHN_NUM; k++) begin
            scan_idx = sdu_chn_t'((int'(ptr) + k) % CHN_NUM);
            if (!nxt_found && !chn_sdu_empty[scan_idx]) begin
                nxt_found = 1'b1;
                nxt_ptr   = scan_idx;
            end
        end
    end

    //------------------------------------------------------------
    // pointer, packet and hold flags
    //------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            ptr <= '0;
        end else if (eop_in || move_idle) begin
            ptr <= nxt_ptr;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            in_pkt <= 1'b0;
        end else if (eop_in) begin
            in_pkt <= 1'b0;
        end else if (|chn_sdu_dval) begin
            in_pkt <= 1'b1;
        end
    end

    // readers only turn pending two cycles after the eop fetch
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            hold <= 1'b0;
        end else if (eop_in) begin
            hold <= 1'b1;
        end else if (!(&rd_idle)) begin
            hold <= 1'b0;  // a reader owns the packet now
        end
    end

    //------------------------------------------------------------
    // checks
    //------------------------------------------------------------
    a_rden_onehot: assert property (
        @(posedge clk_sys) disable iff (!rst_sys)
        $onehot0(sdu_chn_rden)
    ) else $error("rden not one-hot: %b", sdu_chn_rden);

    a_rden_not_empty: assert property (
        @(posedge clk_sys) disable iff (!rst_sys)
        (sdu_chn_rden & chn_sdu_empty) == '0
    ) else $error("rden toward empty channel: rden %b empty %b",
                  sdu_chn_rden, chn_sdu_empty);

endmodule

// File: sdu_pkg.sv
// shared widths, word layout and types of the 16-to-1 packet scheduler
// word layout is sop, eop and a 16-bit payload
package sdu_pkg;

    //------------------------------------------------------------
    // sizes
    //------------------------------------------------------------
    parameter int CHN_NUM       = 16;  // channels into the scheduler
    parameter int CHN_NUM_WIDTH = 4;   // channel index width
    parameter int DATA_WIDTH    = 18;  // flags plus payload
    parameter int ADDR_WIDTH    = 10;  // 1024 buffer words

    //------------------------------------------------------------
    // word layout
    //------------------------------------------------------------
    parameter int SOP_BIT    = 17;
    parameter int EOP_BIT    = 16;
    parameter int STAMP_WORD = 2;      // word index that carries the sequence number

    //------------------------------------------------------------
    // types
    //------------------------------------------------------------
    typedef logic [DATA_WIDTH-1:0]    sdu_word_t;     // sop, eop, payload
    typedef logic [ADDR_WIDTH-1:0]    sdu_addr_t;     // buffer address
    typedef logic [CHN_NUM_WIDTH-1:0] sdu_chn_t;      // channel index
    typedef logic [DATA_WIDTH-3:0]    sdu_seq_t;      // fills the payload field
    typedef logic [CHN_NUM-1:0]       sdu_chn_vec_t;  // one bit per channel

endpackage

// File: sdu_pkt_buffer.sv
`timescale 1ns/10ps
// shared packet buffer
// one write port, one registered read port per reader
module sdu_pkt_buffer
    import sdu_pkg::*;
(
    input  logic       clk_sys,
    input  logic       wr_en,
    input  sdu_addr_t  wr_addr,
    input  sdu_word_t  wr_data,
    input  sdu_addr_t  rd_addr0,
    input  sdu_addr_t  rd_addr1,
    input  logic [1:0] rd_en,      // bit 0 reader 0, bit 1 reader 1
    output sdu_word_t  rd_data0,
    output sdu_word_t  rd_data1
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    sdu_word_t mem [DEPTH];

    //------------------------------------------------------------
    // write port
    //------------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    //------------------------------------------------------------
    // read ports, data one cycle after the enable
    //------------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (rd_en[0]) begin
            rd_data0 <= mem[rd_addr0];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rd_en[1]) begin
            rd_data1 <= mem[rd_addr1];
        end
    end

endmodule

// File: sdu_pkt_reader.sv
`timescale 1ns/10ps
// one output port of the scheduler
// reads the current packet out of the buffer word by word on request
module sdu_pkt_reader
    import sdu_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  logic      pkt_done,      // a whole packet sits in the buffer
    input  logic      fifo_rdreq,
    input  sdu_word_t buf_data,
    output logic      rd_en,
    output sdu_addr_t rd_addr,
    output logic      fifo_rd_dval,
    output sdu_word_t fifo_rd_data,
    output logic      rd_idle
);

    logic      pending;   // packet not yet delivered to its eop
    logic      dval_q;
    logic      eop_dlv;   // eop on the output this cycle
    sdu_addr_t rd_ptr;

    assign eop_dlv      = dval_q && buf_data[EOP_BIT];
    assign rd_en        = pending && fifo_rdreq && !eop_dlv;  // no read past the eop
    assign rd_addr      = rd_ptr;
    assign fifo_rd_dval = dval_q;
    assign fifo_rd_data = buf_data;
    assign rd_idle      = !pending;

    //------------------------------------------------------------
    // pending flag
    //------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            pending <= 1'b0;
        end else if (pkt_done) begin
            pending <= 1'b1;
        end else if (eop_dlv) begin
            pending <= 1'b0;  // idle from the next cycle
        end
    end

    //------------------------------------------------------------
    // read pointer and data valid
    //------------------------------------------------------------
    // follows the write address word for word
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            dval_q <= 1'b0;
        end else begin
            dval_q <= rd_en;  // buffer read latency
        end
    end

    // every output word answers a request made while pending
    a_dval_after_req: assert property (
        @(posedge clk_sys) disable iff (!rst_sys)
        fifo_rd_dval |-> $past(fifo_rdreq && pending)
    ) else $error("fifo_rd_dval without a pending request one cycle earlier");

endmodule

// File: sdu_pkt_stamp.sv
`timescale 1ns/10ps
// buffer write path
// replaces the third word of each packet with a running sequence number
module sdu_pkt_stamp
    import sdu_pkg::*;
(
    input  logic         clk_sys,
    input  logic         rst_sys,
    input  sdu_chn_vec_t chn_sdu_dval,
    input  sdu_word_t    chn_sdu_data,
    output logic         wr_en,
    output sdu_addr_t    wr_addr,
    output sdu_word_t    wr_data,
    output logic         pkt_done,     // eop written this cycle
    output logic         eop_in        // to the arbiter, same cycle as the fetch
);

    localparam int IDX_W = $clog2(STAMP_WORD + 2);

    logic             acc;        // a word is accepted this cycle
    logic             sop_in;
    logic [IDX_W-1:0] word_idx;   // index of the next word in the packet
    logic             stamp_hit;
    sdu_seq_t         seq_cnt;

    assign acc       = |chn_sdu_dval;
    assign sop_in    = acc && chn_sdu_data[SOP_BIT];
    assign eop_in    = acc && chn_sdu_data[EOP_BIT];
    assign stamp_hit = acc && !chn_sdu_data[SOP_BIT]
                       && (word_idx == IDX_W'(STAMP_WORD));

    //------------------------------------------------------------
    // packet position and sequence number
    //------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            word_idx <= '0;
        end else if (sop_in) begin
            word_idx <= IDX_W'(1);
        end else if (acc && (word_idx <= IDX_W'(STAMP_WORD))) begin
            word_idx <= word_idx + 1'b1;  // saturates past the stamp word
        end
    end

    // first packet carries 1
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            seq_cnt <= '0;
        end else if (sop_in) begin
            seq_cnt <= seq_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------
    // registered write
    //------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            wr_en    <= 1'b0;
            pkt_done <= 1'b0;
        end else begin
            wr_en    <= acc;
            pkt_done <= eop_in;
        end
    end

    always_ff @(posedge clk_sys) begin
        wr_data <= stamp_hit ? {1'b0, 1'b0, seq_cnt} : chn_sdu_data;
    end

    // wraps at the buffer size
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            wr_addr <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

endmodule

// File: sdu_top.sv
`timescale 1ns/10ps
// 16-to-1 packet scheduler top level
// channels drained round-robin into a shared buffer read by two ports
module sdu_top
    import sdu_pkg::*;
#(
    parameter int CHN_NUM = sdu_pkg::CHN_NUM
) (
    input  logic         clk_sys,
    input  logic         rst_sys,
    input  sdu_chn_vec_t chn_sdu_empty,
    input  sdu_chn_vec_t chn_sdu_dval,
    input  sdu_word_t    chn_sdu_data,
    output sdu_chn_vec_t sdu_chn_rden,
    input  logic         fifo_rdreq0,
    output logic         fifo_rd_dval0,
    output sdu_word_t    fifo_rd_data0,
    input  logic         fifo_rdreq1,
    output logic         fifo_rd_dval1,
    output sdu_word_t    fifo_rd_data1
);

    logic       eop_in;
    logic       pkt_done;
    logic       wr_en;
    sdu_addr_t  wr_addr;
    sdu_word_t  wr_data;
    logic [1:0] rd_en;
    logic [1:0] rd_idle;
    sdu_addr_t  rd_addr0;
    sdu_addr_t  rd_addr1;
    sdu_word_t  rd_data0;
    sdu_word_t  rd_data1;

    //------------------------------------------------------------
    // fetch side
    //------------------------------------------------------------
    sdu_chn_arbiter #(
        .CHN_NUM (CHN_NUM)
    ) u_arbiter (
        .clk_sys, .rst_sys, .chn_sdu_empty, .chn_sdu_dval,
        .eop_in, .rd_idle, .sdu_chn_rden
    );

    sdu_pkt_stamp u_stamp (
        .clk_sys, .rst_sys, .chn_sdu_dval, .chn_sdu_data,
        .wr_en, .wr_addr, .wr_data, .pkt_done, .eop_in
    );

    sdu_pkt_buffer u_buffer (
        .clk_sys, .wr_en, .wr_addr, .wr_data,
        .rd_addr0, .rd_addr1, .rd_en, .rd_data0, .rd_data1
    );

    //------------------------------------------------------------
    // output ports
    //------------------------------------------------------------
    sdu_pkt_reader u_reader0 (
        .clk_sys, .rst_sys, .pkt_done,
        .fifo_rdreq   (fifo_rdreq0),
        .buf_data     (rd_data0),
        .rd_en        (rd_en[0]),
        .rd_addr      (rd_addr0),
        .fifo_rd_dval (fifo_rd_dval0),
        .fifo_rd_data (fifo_rd_data0),
        .rd_idle      (rd_idle[0])
    );

    sdu_pkt_reader u_reader1 (
        .clk_sys, .rst_sys, .pkt_done,
        .fifo_rdreq   (fifo_rdreq1),
        .buf_data     (rd_data1),
        .rd_en        (rd_en[1]),
        .rd_addr      (rd_addr1),
        .fifo_rd_dval (fifo_rd_dval1),
        .fifo_rd_data (fifo_rd_data1),
        .rd_idle      (rd_idle[1])
    );

endmodule

// File: tb.f
sdu_pkg.sv
sdu_chn_arbiter.sv
sdu_pkt_stamp.sv
sdu_pkt_buffer.sv
sdu_pkt_reader.sv
sdu_top.sv
tb_chn_model.sv
tb_sdu_top.sv

// File: tb_chn_model.sv
`timescale 1ns/10ps
// sixteen show-ahead channel FIFOs in front of the scheduler
// a channel reports non-empty only while it holds a whole packet
module tb_chn_model
    import sdu_pkg::*;
#(
    parameter int CHN_NUM = sdu_pkg::CHN_NUM
) (
    input  logic         clk_sys,
    input  sdu_chn_vec_t rden,
    output sdu_chn_vec_t empty,
    output sdu_chn_vec_t dval,
    output sdu_word_t    data
);

    sdu_word_t    fifo_q [CHN_NUM][$];
    sdu_word_t    head [CHN_NUM];   // show-ahead word of each channel
    sdu_chn_vec_t pop_vec;

    // recount whole packets and refresh the head words
    task automatic refresh_flags();
        int eops;
        for (int i = 0; i < CHN_NUM; i++) begin
            eops = 0;
            for (int j = 0; j < fifo_q[i].size(); j++) begin
                if (fifo_q[i][j][EOP_BIT]) begin
                    eops++;
                end
            end
            empty[i] = (eops == 0);
            head[i]  = (fifo_q[i].size() > 0) ? fifo_q[i][0] : '0;
        end
    endtask

    task automatic push_word(input int chn, input sdu_word_t word);
        fifo_q[chn].push_back(word);
        refresh_flags();
    endtask

    initial begin
        refresh_flags();
    end

    assign dval = rden;  // data valid together with the read enable

    always_comb begin
        data = '0;
        for (int i = 0; i < CHN_NUM; i++) begin
            if (rden[i]) begin
                data = head[i];
            end
        end
    end

    //------------------------------------------------------------
    // pop shortly after the edge that took the word
    //------------------------------------------------------------
    always @(posedge clk_sys) begin
        pop_vec = rden;
        #1;
        for (int i = 0; i < CHN_NUM; i++) begin
            if (pop_vec[i] && fifo_q[i].size() > 0) begin
                void'(fifo_q[i].pop_front());
            end
        end
        if (|pop_vec) begin
            refresh_flags();
        end
    end

endmodule

// File: tb_sdu_top.sv
`timescale 1ns/10ps
// testbench of the packet scheduler
// random packets into the channels, random reads on both ports
module tb_sdu_top;
    import sdu_pkg::*;

    localparam int PKT_NUM   = 48;
    localparam int MAX_LEN   = 12;
    localparam int CYC_LIMIT = PKT_NUM * MAX_LEN * 8 + 1000;

    logic         clk_sys;
    logic         rst_sys;
    sdu_chn_vec_t chn_sdu_empty;
    sdu_chn_vec_t chn_sdu_dval;
    sdu_chn_vec_t sdu_chn_rden;
    sdu_word_t    chn_sdu_data;
    logic         fifo_rdreq0;
    logic         fifo_rdreq1;
    logic         fifo_rd_dval0;
    logic         fifo_rd_dval1;
    sdu_word_t    fifo_rd_data0;
    sdu_word_t    fifo_rd_data1;

    int        err_cnt;
    int        cyc_cnt;
    int        eop_cnt0;
    int        eop_cnt1;
    logic      filled_any;
    sdu_seq_t  seq_exp;
    sdu_word_t src_q [CHN_NUM][$];   // words pushed per channel
    sdu_word_t exp0_q [$];
    sdu_word_t exp1_q [$];
    logic      rr_valid;             // next channel is known
    sdu_chn_t  rr_exp;
    logic      eop_fetch_q;          // eop fetched last cycle, written now
    logic      pend0;                // expected pending flag of each reader
    logic      pend1;
    logic      dval_exp0;            // expected data valid this cycle
    logic      dval_exp1;

    sdu_top #(.CHN_NUM(CHN_NUM)) sdu_top_i (.*);

    tb_chn_model #(.CHN_NUM(CHN_NUM)) u_chn_model (
        .clk_sys, .rden(sdu_chn_rden), .empty(chn_sdu_empty),
        .dval(chn_sdu_dval), .data(chn_sdu_data)
    );

    initial clk_sys = 1'b0;
    always #20 clk_sys = ~clk_sys;

    task automatic log_mismatch(input string name, input int expv, input int actv);
        err_cnt++;
        $display("** Error %s: expected %h actual %h", name, expv, actv);
    endtask

    task automatic log_failure(input string what);
        err_cnt++;
        $display("failure: %s", what);
    endtask

    function automatic sdu_chn_t onehot_index(input sdu_chn_vec_t vec);
        sdu_chn_t idx;
        idx = '0;
        for (int i = 0; i < CHN_NUM; i++) begin
            if (vec[i]) idx = sdu_chn_t'(i);
        end
        return idx;
    endfunction

    task automatic fill_channel(input int chn, input int len);
        sdu_word_t w;
        for (int i = 0; i < len; i++) begin
            w = {(i == 0), (i == len - 1), 16'($urandom)};
            src_q[chn].push_back(w);
            u_chn_model.push_word(chn, w);
        end
        filled_any = 1'b1;
    endtask

    // copy the served packet to both readers, word 2 carries the sequence
    task automatic take_packet(input sdu_chn_t chn);
        sdu_word_t w;
        int        idx;
        idx = 0;
        seq_exp++;
        w = '0;
        while (!w[EOP_BIT]) begin
            if (src_q[chn].size() == 0) begin
                log_failure("packet fetched from a channel that was never filled");
                return;
            end
            w = src_q[chn].pop_front();
            exp0_q.push_back((idx == STAMP_WORD) ? {2'b00, seq_exp} : w);
            exp1_q.push_back((idx == STAMP_WORD) ? {2'b00, seq_exp} : w);
            idx++;
        end
    endtask

    task automatic check_word(input int rdr, input sdu_word_t act);
        sdu_word_t expv;
        if ((rdr == 0 && exp0_q.size() == 0) || (rdr == 1 && exp1_q.size() == 0)) begin
            log_failure($sformatf("reader%0d delivered a word nobody expected", rdr));
        end else begin
            expv = (rdr == 0) ? exp0_q.pop_front() : exp1_q.pop_front();
            assert (act == expv)
                else log_mismatch($sformatf("reader%0d_data", rdr), expv, act);
        end
    endtask

    //------------------------------------------------------------
    // scoreboard
    //------------------------------------------------------------
    always @(posedge clk_sys) begin
        if (rst_sys && (|sdu_chn_rden)) begin
            if (chn_sdu_data[SOP_BIT]) begin
                if (rr_valid) begin
                    assert (onehot_index(sdu_chn_rden) == rr_exp)
                        else log_mismatch("round_robin", rr_exp, onehot_index(sdu_chn_rden));
                end
                rr_valid = 1'b0;
                take_packet(onehot_index(sdu_chn_rden));
            end
            if (chn_sdu_data[EOP_BIT]) begin
                for (int k = CHN_NUM - 1; k >= 1; k--) begin
                    if (!chn_sdu_empty[(onehot_index(sdu_chn_rden) + k) % CHN_NUM]) begin
                        rr_valid = 1'b1;
                        rr_exp   = sdu_chn_t'((onehot_index(sdu_chn_rden) + k) % CHN_NUM);
                    end
                end
            end
        end
        // no reader may run ahead into the next packet
        if (rst_sys && fifo_rd_dval0) begin
            assert (eop_cnt1 >= eop_cnt0) else log_mismatch("reader0_order", eop_cnt0, eop_cnt1);
        end
        if (rst_sys && fifo_rd_dval1) begin
            assert (eop_cnt0 >= eop_cnt1) else log_mismatch("reader1_order", eop_cnt1, eop_cnt0);
        end
        if (rst_sys && fifo_rd_dval0) begin
            check_word(0, fifo_rd_data0);
            if (fifo_rd_data0[EOP_BIT]) eop_cnt0++;
        end
        if (rst_sys && fifo_rd_dval1) begin
            check_word(1, fifo_rd_data1);
            if (fifo_rd_data1[EOP_BIT]) eop_cnt1++;
        end
        // data valid exactly one cycle after a request while pending
        if (rst_sys) begin
            assert (fifo_rd_dval0 == dval_exp0)
                else log_mismatch("reader0_dval", dval_exp0, fifo_rd_dval0);
            assert (fifo_rd_dval1 == dval_exp1)
                else log_mismatch("reader1_dval", dval_exp1, fifo_rd_dval1);
        end
        // a request in the cycle that delivers the eop reads nothing
        dval_exp0 = fifo_rdreq0 && pend0 && !(fifo_rd_dval0 && fifo_rd_data0[EOP_BIT]);
        dval_exp1 = fifo_rdreq1 && pend1 && !(fifo_rd_dval1 && fifo_rd_data1[EOP_BIT]);
        if (eop_fetch_q) begin
            pend0 = 1'b1;  // eop written this cycle
            pend1 = 1'b1;
        end else begin
            if (fifo_rd_dval0 && fifo_rd_data0[EOP_BIT]) pend0 = 1'b0;
            if (fifo_rd_dval1 && fifo_rd_data1[EOP_BIT]) pend1 = 1'b0;
        end
        eop_fetch_q = rst_sys && (|sdu_chn_rden) && chn_sdu_data[EOP_BIT];
    end

    a_idle_before_fill: assert property (@(posedge clk_sys) disable iff (!rst_sys)
        !filled_any |-> (sdu_chn_rden == '0 && !fifo_rd_dval0 && !fifo_rd_dval1)
    ) else log_failure("rden or dval active before any channel was filled");

    a_rden_legal: assert property (@(posedge clk_sys) disable iff (!rst_sys)
        $onehot0(sdu_chn_rden) && ((sdu_chn_rden & chn_sdu_empty) == '0)
    ) else log_failure("rden not one-hot or aimed at an empty channel");

    // reader requests, about 60 percent duty
    always @(posedge clk_sys) begin
        #2;
        fifo_rdreq0 = (($urandom % 100) < 60);
        fifo_rdreq1 = (($urandom % 100) < 60);
    end

    always @(posedge clk_sys) begin
        cyc_cnt++;
        if (cyc_cnt >= CYC_LIMIT) begin
            $display("timeout after %0d cycles, readers did not finish", cyc_cnt);
            $display("errors: %0d", err_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    //------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------
    initial begin
        void'($urandom(32'h09fb_52de));
        rst_sys     = 1'b0;
        fifo_rdreq0 = 1'b0;
        fifo_rdreq1 = 1'b0;
        filled_any  = 1'b0;
        err_cnt  = 0;
        cyc_cnt  = 0;
        eop_cnt0 = 0;
        eop_cnt1 = 0;
        seq_exp  = '0;
        rr_valid = 1'b0;
        rr_exp   = '0;
        eop_fetch_q = 1'b0;
        pend0       = 1'b0;
        pend1       = 1'b0;
        dval_exp0   = 1'b0;
        dval_exp1   = 1'b0;
        repeat (10) @(posedge clk_sys);
        #2 rst_sys = 1'b1;
        repeat (5) @(posedge clk_sys);
        for (int p = 0; p < PKT_NUM; p++) begin
            repeat ($urandom % 13) @(posedge clk_sys);
            #2 fill_channel($urandom % CHN_NUM, 4 + ($urandom % (MAX_LEN - 3)));
        end
        while (eop_cnt0 < PKT_NUM || eop_cnt1 < PKT_NUM) @(posedge clk_sys);
        repeat (5) @(posedge clk_sys);
        if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
            log_failure("expected words left over after the last packet");
        end
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
